//--- compile.f
crypto_pkg.sv
range_if.sv
range_walker.sv
sm_selector.sv
crypto_fsm.sv
result_writer.sv
crypto_control.sv
tb_crypto_control.sv

//--- tb_crypto_control.sv
`timescale 1ns/1ns
`default_nettype none

module tb_crypto_control;
    import crypto_pkg::*;

    // one operation of the stimulus table
    typedef struct packed
    {
        cmd_e       cmd;
        logic       data_valid;
        logic       key_valid;
        word_t      pc;
        word_t      pub_start;
        word_t      pub_end;
        word_t      sec_start;
        word_t      sec_end;
        word_t      id;
        logic [3:0] hold;
    } row_t;

    localparam int TIMEOUT_CYCLES = 200;

    logic       clk;
    logic       reset;
    logic       start;
    cmd_e       cmd;
    word_t      pc;
    word_t      r15;
    word_t      sm_data;
    word_t      sm_prev_id;
    logic       sm_data_select_valid;
    logic       sm_key_select_valid;
    logic       busy;
    sm_req_e    sm_request;
    word_t      sm_data_select;
    word_t      sm_key_select;
    logic       mb_en;
    logic [1:0] mb_wr;
    word_t      mab;
    word_t      data_out;
    logic       reg_write;
    word_t      dest_reg;
    word_t      reg_data_out;

    row_t        rows[$];
    row_t        cur;
    word_t       write_addr[$];
    word_t       write_data[$];
    word_t       expect_addr[$];
    logic [31:0] lcg_state;
    int          value_errors;
    int          timeouts;
    int          write_errors;
    int          i;

    crypto_control dut_i
    (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .cmd                  (cmd),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data              (sm_data),
        .sm_prev_id           (sm_prev_id),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .busy                 (busy),
        .sm_request           (sm_request),
        .sm_data_select       (sm_data_select),
        .sm_key_select        (sm_key_select),
        .mb_en                (mb_en),
        .mb_wr                (mb_wr),
        .mab                  (mab),
        .data_out             (data_out),
        .reg_write            (reg_write),
        .dest_reg             (dest_reg),
        .reg_data_out         (reg_data_out)
    );

    always #5 clk = ~clk;

    // module table answers for the current row
    always_comb
    begin
        case (sm_request)
            SM_REQ_PUBSTART: sm_data = cur.pub_start;
            SM_REQ_PUBEND:   sm_data = cur.pub_end;
            SM_REQ_SECSTART: sm_data = cur.sec_start;
            SM_REQ_SECEND:   sm_data = cur.sec_end;
            SM_REQ_ID:       sm_data = cur.id;
            default:         sm_data = '0;
        endcase
    end

    // record memory writes mid-cycle
    always @(negedge clk)
    begin
        if (mb_en && mb_wr == 2'b11)
        begin
            write_addr.push_back(mab);
            write_data.push_back(data_out);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_request(input string name, input sm_req_e got, input sm_req_e exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_cmd_result(input word_t dest, input word_t data,
                                    input word_t exp_dest, input word_t exp_data);
        if (dest !== exp_dest || data !== exp_data)
        begin
            $display("FAILED dest_reg/reg_data_out: got %h/%h expected %h/%h",
                     dest, data, exp_dest, exp_data);
            value_errors++;
        end
    endtask

    task automatic add_row(input cmd_e c, input logic dv, input logic kv, input word_t p,
                           input word_t ps, input word_t pe, input word_t ss,
                           input word_t se, input word_t id, input logic [3:0] hold);
        row_t r;
        r = '{c, dv, kv, p, ps, pe, ss, se, id, hold};
        rows.push_back(r);
    endtask

    task automatic run_row(input row_t row);
        word_t exp_dest;
        word_t exp_data;
        word_t a;
        logic  accepted;
        int    cycles;
        int    n;
        int    k;
        lcg_state = lcg_next(lcg_state);
        r15 = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        sm_prev_id = lcg_state[31:16];
        cur = row;
        cmd = row.cmd;
        pc = row.pc;
        sm_data_select_valid = row.data_valid;
        sm_key_select_valid = row.key_valid;
        write_addr.delete();
        write_data.delete();
        expect_addr.delete();
        start = 1'b1;

        case (row.cmd)
            CMD_ID:      accepted = row.data_valid;
            CMD_DISABLE: accepted = row.key_valid;
            default:     accepted = 1'b1;
        endcase
        exp_dest = DEST_R15;
        exp_data = RESULT_FAIL;
        if (accepted)
        begin
            case (row.cmd)
                CMD_DISABLE:
                begin
                    exp_dest = DEST_PC;
                    exp_data = r15;
                    for (a = row.pub_start; a < row.pub_end; a = a + WORD_STEP)
                        expect_addr.push_back(a);
                    for (a = row.sec_start; a < row.sec_end; a = a + WORD_STEP)
                        expect_addr.push_back(a);
                end
                CMD_ID:  exp_data = row.id;
                default: exp_data = sm_prev_id;
            endcase
        end

        cycles = 0;
        while (reg_write !== 1'b1 && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles == row.hold)
                start = 1'b0;
            if (reg_write !== 1'b1)
                check_flag("busy", busy, 1'b1);
        end
        start = 1'b0;
        if (reg_write !== 1'b1)
        begin
            $display("timed out waiting for reg_write on cmd %s", row.cmd.name());
            timeouts++;
            return;
        end

        check_flag("busy", busy, 1'b0);
        check_cmd_result(dest_reg, reg_data_out, exp_dest, exp_data);
        if (row.cmd != CMD_DISABLE && cycles != 3)
        begin
            $display("FAILED reg_write latency: got %h expected %h", cycles, 3);
            value_errors++;
        end
        // id looks up the module holding r15, disable the caller
        if (row.cmd == CMD_ID)
            check_word("sm_data_select", sm_data_select, r15);
        else if (row.cmd == CMD_DISABLE)
            check_word("sm_data_select", sm_data_select, row.pc);
        check_word("sm_key_select", sm_key_select, row.pc);

        // a single result and no new command afterwards
        @(posedge clk);
        #1;
        check_flag("reg_write", reg_write, 1'b0);
        check_cmd_result(dest_reg, reg_data_out, 16'h0000, 16'h0000);
        cmd = CMD_NONE;
        sm_data_select_valid = 1'b0;
        sm_key_select_valid = 1'b0;
        repeat (2)
        begin
            @(posedge clk);
            #1;
            check_flag("busy", busy, 1'b0);
            check_flag("reg_write", reg_write, 1'b0);
        end

        n = expect_addr.size();
        if (write_addr.size() < n)
        begin
            $display("memory write missing: saw %0d writes, expected %0d", write_addr.size(), n);
            write_errors++;
            n = write_addr.size();
        end
        else if (write_addr.size() > n)
        begin
            $display("unexpected memory write: saw %0d writes, expected %0d", write_addr.size(), n);
            write_errors++;
        end
        for (k = 0; k < n; k++)
        begin
            check_word("mab", write_addr[k], expect_addr[k]);
            check_word("data_out", write_data[k], 16'h0000);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        cmd = CMD_NONE;
        pc = '0;
        r15 = '0;
        sm_prev_id = '0;
        sm_data_select_valid = 1'b0;
        sm_key_select_valid = 1'b0;
        cur = '0;
        lcg_state = 32'd63;
        value_errors = 0;
        timeouts = 0;
        write_errors = 0;

        //      cmd          dv    kv    pc
        //      pub_start pub_end   sec_start sec_end   id        hold
        add_row(CMD_ID,      1'b1, 1'b0, 16'h4000,
                16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0003, 4'd1);
        add_row(CMD_ID,      1'b0, 1'b1, 16'h4000,
                16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0007, 4'd1);
        add_row(CMD_ID_PREV, 1'b0, 1'b0, 16'h4010,
                16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0002, 4'd1);
        add_row(CMD_DISABLE, 1'b1, 1'b1, 16'h8000,
                16'h1000, 16'h1008, 16'h2000, 16'h2006, 16'h0005, 4'd3);
        add_row(CMD_DISABLE, 1'b0, 1'b1, 16'h8100,
                16'h1100, 16'h1100, 16'h2100, 16'h2104, 16'h0006, 4'd1);
        add_row(CMD_DISABLE, 1'b1, 1'b1, 16'h8200,
                16'h1200, 16'h1206, 16'h2200, 16'h21f0, 16'h0008, 4'd2);
        add_row(CMD_DISABLE, 1'b1, 1'b0, 16'h8300,
                16'h1300, 16'h1310, 16'h2300, 16'h2310, 16'h0009, 4'd1);
        add_row(CMD_ID_PREV, 1'b0, 1'b0, 16'h4020,
                16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0004, 4'd2);
        add_row(CMD_ID,      1'b1, 1'b1, 16'h4030,
                16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h000a, 4'd1);

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // quiet outputs before the first command
        repeat (4)
        begin
            @(posedge clk);
            #1;
            check_flag("busy", busy, 1'b0);
            check_flag("mb_en", mb_en, 1'b0);
            check_flag("reg_write", reg_write, 1'b0);
            check_request("sm_request", sm_request, SM_REQ_NONE);
        end

        for (i = 0; i < rows.size() && timeouts == 0; i++)
        begin
            run_row(rows[i]);
        end

        $display("errors: %0d value, %0d timeout, %0d memory write",
                 value_errors, timeouts, write_errors);
        if (value_errors == 0 && timeouts == 0 && write_errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- crypto_control.sv
`timescale 1ns/1ns
`default_nettype none

module crypto_control
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  crypto_pkg::cmd_e    cmd,
    input  crypto_pkg::word_t   pc,
    input  crypto_pkg::word_t   r15,
    input  crypto_pkg::word_t   sm_data,
    input  crypto_pkg::word_t   sm_prev_id,
    input  logic                sm_data_select_valid,
    input  logic                sm_key_select_valid,
    output logic                busy,
    output crypto_pkg::sm_req_e sm_request,
    output crypto_pkg::word_t   sm_data_select,
    output crypto_pkg::word_t   sm_key_select,
    output logic                mb_en,
    output logic [1:0]          mb_wr,
    output crypto_pkg::word_t   mab,
    output crypto_pkg::word_t   data_out,
    output logic                reg_write,
    output crypto_pkg::word_t   dest_reg,
    output crypto_pkg::word_t   reg_data_out
);

    logic sm_valid;
    logic report_ok;
    logic report_fail;

    range_if rng_i ();

    sm_selector sm_selector_i
    (
        .clk                  (clk),
        .reset                (reset),
        .cmd                  (cmd),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .sm_data_select       (sm_data_select),
        .sm_key_select        (sm_key_select),
        .sm_valid             (sm_valid)
    );

    crypto_fsm crypto_fsm_i
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .cmd         (cmd),
        .sm_valid    (sm_valid),
        .rng         (rng_i.ctrl),
        .busy        (busy),
        .sm_request  (sm_request),
        .mb_en       (mb_en),
        .mb_wr       (mb_wr),
        .data_out    (data_out),
        .report_ok   (report_ok),
        .report_fail (report_fail)
    );

    // bounds are loaded straight from the module table answer
    range_walker range_walker_i
    (
        .clk     (clk),
        .sm_data (sm_data),
        .rng     (rng_i.walker)
    );

    result_writer result_writer_i
    (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .report_ok    (report_ok),
        .report_fail  (report_fail),
        .sm_data      (sm_data),
        .sm_prev_id   (sm_prev_id),
        .r15          (r15),
        .reg_write    (reg_write),
        .dest_reg     (dest_reg),
        .reg_data_out (reg_data_out)
    );

    assign mab = rng_i.addr;

endmodule

`default_nettype wire

//--- result_writer.sv
`timescale 1ns/1ns
`default_nettype none

module result_writer
(
    input  logic              clk,
    input  logic              reset,
    input  crypto_pkg::cmd_e  cmd,
    input  logic              report_ok,
    input  logic              report_fail,
    input  crypto_pkg::word_t sm_data,
    input  crypto_pkg::word_t sm_prev_id,
    input  crypto_pkg::word_t r15,
    output logic              reg_write,
    output crypto_pkg::word_t dest_reg,
    output crypto_pkg::word_t reg_data_out
);
    import crypto_pkg::*;

    word_t dest_next;
    word_t data_next;

    always_comb
    begin
        dest_next = DEST_R15;
        data_next = RESULT_FAIL;
        if (report_ok)
        begin
            case (cmd)
                CMD_DISABLE:
                begin
                    // jump back to the continuation address
                    dest_next = DEST_PC;
                    data_next = r15;
                end
                CMD_ID:
                begin
                    // sm_data carries the answer to SM_REQ_ID
                    data_next = sm_data;
                end
                CMD_ID_PREV:
                begin
                    data_next = sm_prev_id;
                end
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || !(report_ok || report_fail))
        begin
            reg_write    <= 1'b0;
            dest_reg     <= '0;
            reg_data_out <= '0;
        end
        else
        begin
            reg_write    <= 1'b1;
            dest_reg     <= dest_next;
            reg_data_out <= data_next;
        end
    end

endmodule

`default_nettype wire

//--- crypto_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module crypto_fsm
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  crypto_pkg::cmd_e    cmd,
    input  logic                sm_valid,
    range_if.ctrl               rng,
    output logic                busy,
    output crypto_pkg::sm_req_e sm_request,
    output logic                mb_en,
    output logic [1:0]          mb_wr,
    output crypto_pkg::word_t   data_out,
    output logic                report_ok,
    output logic                report_fail
);
    import crypto_pkg::*;

    typedef enum logic [3:0]
    {
        IDLE,
        CHECK_SM,
        CODE_START,
        CODE_END,
        CLEAR_CODE,
        DATA_START,
        DATA_END,
        CLEAR_DATA,
        SUCCESS,
        FAIL
    } state_e;

    state_e state;
    state_e next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (start)
                begin
                    next_state = CHECK_SM;
                end
            end
            CHECK_SM:
            begin
                if (!sm_valid)
                begin
                    next_state = FAIL;
                end
                else if (cmd == CMD_DISABLE)
                begin
                    next_state = CODE_START;
                end
                else
                begin
                    next_state = SUCCESS;
                end
            end
            CODE_START:
            begin
                next_state = CODE_END;
            end
            CODE_END:
            begin
                next_state = CLEAR_CODE;
            end
            CLEAR_CODE:
            begin
                if (rng.done)
                begin
                    next_state = DATA_START;
                end
            end
            DATA_START:
            begin
                next_state = DATA_END;
            end
            DATA_END:
            begin
                next_state = CLEAR_DATA;
            end
            CLEAR_DATA:
            begin
                if (rng.done)
                begin
                    next_state = SUCCESS;
                end
            end
            default:
            begin
                // SUCCESS and FAIL both end the command
                next_state = IDLE;
            end
        endcase
    end

    // outputs follow the current state only
    always_comb
    begin
        busy           = (state != IDLE);
        sm_request     = SM_REQ_NONE;
        mb_en          = 1'b0;
        mb_wr          = 2'b00;
        data_out       = '0;
        rng.load_base  = 1'b0;
        rng.load_limit = 1'b0;
        rng.step       = 1'b0;
        report_ok      = 1'b0;
        report_fail    = 1'b0;
        case (state)
            CODE_START:
            begin
                sm_request    = SM_REQ_PUBSTART;
                rng.load_base = 1'b1;
            end
            CODE_END:
            begin
                sm_request     = SM_REQ_PUBEND;
                rng.load_limit = 1'b1;
            end
            DATA_START:
            begin
                sm_request    = SM_REQ_SECSTART;
                rng.load_base = 1'b1;
            end
            DATA_END:
            begin
                sm_request     = SM_REQ_SECEND;
                rng.load_limit = 1'b1;
            end
            CLEAR_CODE, CLEAR_DATA:
            begin
                // zero one word per cycle until the limit is reached
                if (!rng.done)
                begin
                    mb_en    = 1'b1;
                    mb_wr    = 2'b11;
                    rng.step = 1'b1;
                end
            end
            SUCCESS:
            begin
                sm_request = SM_REQ_ID;
                report_ok  = 1'b1;
            end
            FAIL:
            begin
                report_fail = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- sm_selector.sv
`timescale 1ns/1ns
`default_nettype none

module sm_selector
(
    input  logic              clk,
    input  logic              reset,
    input  crypto_pkg::cmd_e  cmd,
    input  crypto_pkg::word_t pc,
    input  crypto_pkg::word_t r15,
    input  logic              sm_data_select_valid,
    input  logic              sm_key_select_valid,
    output crypto_pkg::word_t sm_data_select,
    output crypto_pkg::word_t sm_key_select,
    output logic              sm_valid
);
    import crypto_pkg::*;

    logic valid_next;

    // id looks up the module holding r15, everything else the caller
    assign sm_data_select = (cmd == CMD_ID) ? r15 : pc;

    // key lookup tells whether the caller itself is a module
    assign sm_key_select = pc;

    always_comb
    begin
        case (cmd)
            CMD_ID:
            begin
                valid_next = sm_data_select_valid;
            end
            CMD_DISABLE:
            begin
                valid_next = sm_key_select_valid;
            end
            CMD_ID_PREV:
            begin
                valid_next = 1'b1;
            end
            default:
            begin
                valid_next = 1'b0;
            end
        endcase
    end

    // ready for the CHECK_SM state one cycle after start
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sm_valid <= 1'b0;
        end
        else
        begin
            sm_valid <= valid_next;
        end
    end

endmodule

`default_nettype wire

//--- range_walker.sv
`timescale 1ns/1ns
`default_nettype none

module range_walker
(
    input  logic              clk,
    input  crypto_pkg::word_t sm_data,
    range_if.walker           rng
);
    import crypto_pkg::*;

    word_t addr_q;
    word_t limit_q;

    // address counter, loaded from the module table or stepped by one word
    always_ff @(posedge clk)
    begin
        if (rng.load_base)
        begin
            addr_q <= sm_data;
        end
        else if (rng.step)
        begin
            addr_q <= addr_q + WORD_STEP;
        end
    end

    // end bound of the current range
    always_ff @(posedge clk)
    begin
        if (rng.load_limit)
        begin
            limit_q <= sm_data;
        end
    end

    assign rng.addr = addr_q;

    // an end at or below the start counts as done right away
    assign rng.done = (addr_q >= limit_q);

endmodule

`default_nettype wire

//--- range_if.sv
`timescale 1ns/1ns
`default_nettype none

interface range_if;
    import crypto_pkg::*;

    // strobes from the controller
    logic  load_base;
    logic  load_limit;
    logic  step;

    // walker state back to the controller
    word_t addr;
    logic  done;

    modport ctrl
    (
        output load_base,
        output load_limit,
        output step,
        input  addr,
        input  done
    );

    modport walker
    (
        input  load_base,
        input  load_limit,
        input  step,
        output addr,
        output done
    );

endinterface

`default_nettype wire

//--- crypto_pkg.sv
`default_nettype none

package crypto_pkg;

    // processor word, also used for addresses and register values
    typedef logic [15:0] word_t;

    // commands handled without a cipher engine
    typedef enum logic [1:0]
    {
        CMD_NONE    = 2'd0,
        CMD_DISABLE = 2'd1,
        CMD_ID      = 2'd2,
        CMD_ID_PREV = 2'd3
    } cmd_e;

    // module table requests, answered on sm_data
    typedef enum logic [2:0]
    {
        SM_REQ_NONE     = 3'd0,
        SM_REQ_PUBSTART = 3'd1,
        SM_REQ_PUBEND   = 3'd2,
        SM_REQ_SECSTART = 3'd3,
        SM_REQ_SECEND   = 3'd4,
        SM_REQ_ID       = 3'd5
    } sm_req_e;

    // byte distance between consecutive words
    localparam word_t WORD_STEP = 16'd2;

    // destination selects for the register file write
    localparam word_t DEST_R15 = 16'h8000;
    localparam word_t DEST_PC  = 16'h0001;

    // value returned to r15 when a command is refused
    localparam word_t RESULT_FAIL = 16'h0000;

endpackage

`default_nettype wire
